// ==== opll_types_pkg.sv ====
// vector types and sequencer state shared by all opll blocks, referenced as opll_types_pkg::name
package opll_types_pkg;

    // cpu side
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // indices
    typedef logic [3:0] chan_t;
    typedef logic [4:0] slot_t;

    // channel settings
    typedef logic [8:0] fnum_t;
    typedef logic [2:0] block_t;
    typedef logic [3:0] inst_t;
    typedef logic [3:0] vol_t;

    // operator settings
    typedef logic [3:0] mul_t;
    // also used for sustain level
    typedef logic [3:0] rate_t;
    typedef logic [5:0] tl_t;
    typedef logic [1:0] ksl_t;
    typedef logic [2:0] fb_t;

    // byte n of a patch sits at bits [8n+7:8n]
    typedef logic [63:0] patch_t;

    // slot walker
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        PRESENT
    } seq_state_t;

endpackage

// ==== opll_map_pkg.sv ====
// register map, patch byte layout and built-in patch table, referenced as opll_map_pkg::name
package opll_map_pkg;

    localparam int NUM_CHAN = 9;
    // two operators per channel
    localparam int NUM_SLOT = 18;

    // register bases, low nibble is the channel
    localparam opll_types_pkg::reg_addr_t REG_PATCH_LAST = 8'h07;
    localparam opll_types_pkg::reg_addr_t REG_FNUM_LO    = 8'h10;
    localparam opll_types_pkg::reg_addr_t REG_FNUM_HI    = 8'h20;
    localparam opll_types_pkg::reg_addr_t REG_INST_VOL   = 8'h30;

    // channel field codes on the decoder to bank strobe
    localparam logic [1:0] FIELD_FNUM_LO  = 2'd0;
    localparam logic [1:0] FIELD_FNUM_HI  = 2'd1;
    localparam logic [1:0] FIELD_INST_VOL = 2'd2;

    // am, vib, egtyp, ksr, mul[3:0]
    localparam int PB_MOD_FLAGS  = 0;
    localparam int PB_CAR_FLAGS  = 1;
    // ksl[7:6], tl[5:0]
    localparam int PB_MOD_KSL_TL = 2;
    // carrier ksl[7:6], carrier wave bit 4, modulator wave bit 3, fb[2:0]
    localparam int PB_CAR_KSL_FB = 3;
    // ar[7:4], dr[3:0]
    localparam int PB_MOD_AR_DR  = 4;
    localparam int PB_CAR_AR_DR  = 5;
    // sl[7:4], rr[3:0]
    localparam int PB_MOD_SL_RR  = 6;
    localparam int PB_CAR_SL_RR  = 7;

    // instruments 1..15, hex written byte 7 first
    localparam opll_types_pkg::patch_t ROM_PATCH [1:15] = '{
        64'h170078D0171E6171,
        64'h1323F7D80D1A4113,
        64'h2321C4F200990113,
        64'h2770648D070E6111,
        64'h280176E1061E2132,
        64'h180071E005162231,
        64'h07118182071D6121,
        64'h070770C0162D2123,
        64'h17106564061B6161,
        64'h0781F085180B6141,
        64'h0410EFEA11830133,
        64'h1222F8F80724C117,
        64'h4240F5D2050C5061,
        64'h020390E903550101,
        64'h13C0E4F103894141
    };

endpackage

// ==== opll_mmr.sv ====
// cpu write decoder, latches the selected register and issues one-cycle bank write strobes
`timescale 1ns/1ps

module opll_mmr (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      write,
    input  logic                      addr,
    input  opll_types_pkg::reg_data_t din,
    output logic                      chan_we,
    output logic [1:0]                chan_field,
    output opll_types_pkg::chan_t     chan_sel,
    output logic                      patch_we,
    output logic [2:0]                patch_byte,
    output opll_types_pkg::reg_data_t wdata
);

    opll_types_pkg::reg_addr_t sel_reg;
    logic [3:0]                sel_lo;
    logic                      data_wr;
    logic                      hit_patch;
    logic                      hit_chan;
    logic [1:0]                field;

    assign sel_lo  = sel_reg[3:0];
    assign data_wr = write && addr;

    // user patch bytes at 0x00..0x07
    assign hit_patch = (sel_reg <= opll_map_pkg::REG_PATCH_LAST);

    // upper nibble picks the field, lower nibble the channel
    always_comb begin
        hit_chan = 1'b0;
        field    = opll_map_pkg::FIELD_FNUM_LO;
        if (sel_lo < opll_map_pkg::NUM_CHAN) begin
            case ({sel_reg[7:4], 4'h0})
                opll_map_pkg::REG_FNUM_LO: begin
                    hit_chan = 1'b1;
                    field    = opll_map_pkg::FIELD_FNUM_LO;
                end
                opll_map_pkg::REG_FNUM_HI: begin
                    hit_chan = 1'b1;
                    field    = opll_map_pkg::FIELD_FNUM_HI;
                end
                opll_map_pkg::REG_INST_VOL: begin
                    hit_chan = 1'b1;
                    field    = opll_map_pkg::FIELD_INST_VOL;
                end
                // rhythm, test and gaps fall through
                default: hit_chan = 1'b0;
            endcase
        end
    end

    // address latch and strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg  <= '0;
            chan_we  <= 1'b0;
            patch_we <= 1'b0;
        end else begin
            if (write && !addr) begin
                sel_reg <= din;
            end
            chan_we  <= data_wr && hit_chan;
            patch_we <= data_wr && hit_patch;
        end
    end

    // payload copy travels with the strobe
    always_ff @(posedge clk) begin
        if (data_wr) begin
            chan_field <= field;
            chan_sel   <= sel_lo;
            patch_byte <= sel_reg[2:0];
            wdata      <= din;
        end
    end

endmodule

// ==== opll_chan_regs.sv ====
// per-channel frequency, key and instrument/volume storage with a channel-indexed read port
`timescale 1ns/1ps

module opll_chan_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      chan_we,
    input  logic [1:0]                chan_field,
    input  opll_types_pkg::chan_t     chan_sel,
    input  opll_types_pkg::reg_data_t wdata,
    input  opll_types_pkg::chan_t     rd_chan,
    output opll_types_pkg::fnum_t     fnum,
    output opll_types_pkg::block_t    block,
    output logic                      key,
    output logic                      sus,
    output opll_types_pkg::inst_t     inst,
    output opll_types_pkg::vol_t      vol
);

    // raw register bytes, one per channel
    opll_types_pkg::reg_data_t fnum_lo  [opll_map_pkg::NUM_CHAN];
    opll_types_pkg::reg_data_t fnum_hi  [opll_map_pkg::NUM_CHAN];
    opll_types_pkg::reg_data_t inst_vol [opll_map_pkg::NUM_CHAN];
    opll_types_pkg::reg_data_t hi_byte;
    opll_types_pkg::reg_data_t iv_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < opll_map_pkg::NUM_CHAN; i++) begin
                fnum_lo[i]  <= '0;
                fnum_hi[i]  <= '0;
                inst_vol[i] <= '0;
            end
        end else if (chan_we) begin
            case (chan_field)
                opll_map_pkg::FIELD_FNUM_LO:  fnum_lo[chan_sel]  <= wdata;
                opll_map_pkg::FIELD_FNUM_HI:  fnum_hi[chan_sel]  <= wdata;
                opll_map_pkg::FIELD_INST_VOL: inst_vol[chan_sel] <= wdata;
                default: ;
            endcase
        end
    end

    assign hi_byte = fnum_hi[rd_chan];
    assign iv_byte = inst_vol[rd_chan];

    // hi byte: sus bit 5, key bit 4, block 3:1, fnum msb bit 0
    assign fnum  = {hi_byte[0], fnum_lo[rd_chan]};
    assign block = hi_byte[3:1];
    assign key   = hi_byte[4];
    assign sus   = hi_byte[5];

    // instrument in the upper nibble, attenuation in the lower
    assign inst = iv_byte[7:4];
    assign vol  = iv_byte[3:0];

endmodule

// ==== opll_patch_regs.sv ====
// user patch bytes plus the built-in table, read by instrument number
`timescale 1ns/1ps

module opll_patch_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      patch_we,
    input  logic [2:0]                patch_byte,
    input  opll_types_pkg::reg_data_t wdata,
    input  opll_types_pkg::inst_t     rd_inst,
    output opll_types_pkg::patch_t    patch
);

    // instrument 0 lives here
    opll_types_pkg::reg_data_t user [8];
    opll_types_pkg::patch_t    user_img;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                user[i] <= '0;
            end
        end else if (patch_we) begin
            user[patch_byte] <= wdata;
        end
    end

    // pack bytes, byte 0 lowest
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            user_img[8*i +: 8] = user[i];
        end
    end

    // 1..15 straight from the table
    always_comb begin
        if (rd_inst == '0) begin
            patch = user_img;
        end else begin
            patch = opll_map_pkg::ROM_PATCH[rd_inst];
        end
    end

endmodule

// ==== opll_slot_seq.sv ====
// slot walker, merges channel and patch settings into one operator record per slot
`timescale 1ns/1ps

module opll_slot_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      out_ready,
    input  opll_types_pkg::fnum_t     fnum,
    input  opll_types_pkg::block_t    block,
    input  logic                      key,
    input  logic                      sus,
    input  opll_types_pkg::inst_t     inst,
    input  opll_types_pkg::vol_t      vol,
    input  opll_types_pkg::patch_t    patch,
    output opll_types_pkg::chan_t     rd_chan,
    output opll_types_pkg::inst_t     rd_inst,
    output logic                      out_valid,
    output opll_types_pkg::slot_t     out_slot,
    output logic                      out_carrier,
    output opll_types_pkg::fnum_t     out_fnum,
    output opll_types_pkg::block_t    out_block,
    output logic                      out_key,
    output logic                      out_sus,
    output logic                      out_am,
    output logic                      out_vib,
    output logic                      out_egtyp,
    output logic                      out_ksr,
    output opll_types_pkg::mul_t      out_mul,
    output opll_types_pkg::ksl_t      out_ksl,
    output opll_types_pkg::tl_t       out_tl,
    output logic                      out_wave,
    output opll_types_pkg::fb_t       out_fb,
    output opll_types_pkg::rate_t     out_ar,
    output opll_types_pkg::rate_t     out_dr,
    output opll_types_pkg::rate_t     out_sl,
    output opll_types_pkg::rate_t     out_rr
);

    opll_types_pkg::seq_state_t state;
    opll_types_pkg::slot_t      slot;
    logic                       carrier;
    logic                       xfer;
    // patch bytes for the current operator
    opll_types_pkg::reg_data_t  flags;
    opll_types_pkg::reg_data_t  ad;
    opll_types_pkg::reg_data_t  sr;
    opll_types_pkg::reg_data_t  mod_kt;
    opll_types_pkg::reg_data_t  car_kf;

    // odd slot is the carrier of channel slot/2
    assign carrier = slot[0];
    assign rd_chan = slot[4:1];
    assign rd_inst = inst;

    assign out_valid = (state == opll_types_pkg::PRESENT);
    assign xfer      = out_valid && out_ready;

    assign mod_kt = patch[8*opll_map_pkg::PB_MOD_KSL_TL +: 8];
    assign car_kf = patch[8*opll_map_pkg::PB_CAR_KSL_FB +: 8];
    assign flags  = carrier ? patch[8*opll_map_pkg::PB_CAR_FLAGS +: 8]
                            : patch[8*opll_map_pkg::PB_MOD_FLAGS +: 8];
    assign ad     = carrier ? patch[8*opll_map_pkg::PB_CAR_AR_DR +: 8]
                            : patch[8*opll_map_pkg::PB_MOD_AR_DR +: 8];
    assign sr     = carrier ? patch[8*opll_map_pkg::PB_CAR_SL_RR +: 8]
                            : patch[8*opll_map_pkg::PB_MOD_SL_RR +: 8];

    // idle -> load -> present, back to load on each transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= opll_types_pkg::IDLE;
            slot  <= '0;
        end else begin
            case (state)
                opll_types_pkg::IDLE:    state <= opll_types_pkg::LOAD;
                opll_types_pkg::LOAD:    state <= opll_types_pkg::PRESENT;
                opll_types_pkg::PRESENT: begin
                    if (xfer) begin
                        state <= opll_types_pkg::LOAD;
                        // wrap after the last carrier
                        if (slot == opll_types_pkg::slot_t'(opll_map_pkg::NUM_SLOT - 1)) begin
                            slot <= '0;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end
                end
                default: state <= opll_types_pkg::IDLE;
            endcase
        end
    end

    // record capture, held through any stall
    always_ff @(posedge clk) begin
        if (state == opll_types_pkg::LOAD) begin
            out_slot    <= slot;
            out_carrier <= carrier;
            out_fnum    <= fnum;
            out_block   <= block;
            out_key     <= key;
            out_sus     <= sus;
            out_am      <= flags[7];
            out_vib     <= flags[6];
            out_egtyp   <= flags[5];
            out_ksr     <= flags[4];
            out_mul     <= flags[3:0];
            out_ksl     <= carrier ? car_kf[7:6] : mod_kt[7:6];
            // carrier level follows channel volume, 3 dB steps
            out_tl      <= carrier ? {vol, 2'b00} : mod_kt[5:0];
            out_wave    <= carrier ? car_kf[4] : car_kf[3];
            // feedback only on the modulator
            out_fb      <= carrier ? 3'd0 : car_kf[2:0];
            out_ar      <= ad[7:4];
            out_dr      <= ad[3:0];
            out_sl      <= sr[7:4];
            out_rr      <= sr[3:0];
        end
    end

endmodule

// ==== opll_core.sv ====
// top of the register front end, cpu writes in and operator records out under valid/ready
`timescale 1ns/1ps

module opll_core (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      write,
    input  logic                      addr,
    input  opll_types_pkg::reg_data_t din,
    input  logic                      out_ready,
    output logic                      out_valid,
    output opll_types_pkg::slot_t     out_slot,
    output logic                      out_carrier,
    output opll_types_pkg::fnum_t     out_fnum,
    output opll_types_pkg::block_t    out_block,
    output logic                      out_key,
    output logic                      out_sus,
    output logic                      out_am,
    output logic                      out_vib,
    output logic                      out_egtyp,
    output logic                      out_ksr,
    output opll_types_pkg::mul_t      out_mul,
    output opll_types_pkg::ksl_t      out_ksl,
    output opll_types_pkg::tl_t       out_tl,
    output logic                      out_wave,
    output opll_types_pkg::fb_t       out_fb,
    output opll_types_pkg::rate_t     out_ar,
    output opll_types_pkg::rate_t     out_dr,
    output opll_types_pkg::rate_t     out_sl,
    output opll_types_pkg::rate_t     out_rr
);

    // decoder to banks
    logic                      chan_we;
    logic [1:0]                chan_field;
    opll_types_pkg::chan_t     chan_sel;
    logic                      patch_we;
    logic [2:0]                patch_byte;
    opll_types_pkg::reg_data_t wdata;
    // banks to sequencer
    opll_types_pkg::chan_t     rd_chan;
    opll_types_pkg::inst_t     rd_inst;
    opll_types_pkg::fnum_t     fnum;
    opll_types_pkg::block_t    block;
    logic                      key;
    logic                      sus;
    opll_types_pkg::inst_t     inst;
    opll_types_pkg::vol_t      vol;
    opll_types_pkg::patch_t    patch;

    opll_mmr i_mmr (
        .clk(clk), .rst(rst), .write(write), .addr(addr), .din(din),
        .chan_we(chan_we), .chan_field(chan_field), .chan_sel(chan_sel),
        .patch_we(patch_we), .patch_byte(patch_byte), .wdata(wdata)
    );

    opll_chan_regs i_chan_regs (
        .clk(clk), .rst(rst), .chan_we(chan_we), .chan_field(chan_field),
        .chan_sel(chan_sel), .wdata(wdata), .rd_chan(rd_chan),
        .fnum(fnum), .block(block), .key(key), .sus(sus), .inst(inst), .vol(vol)
    );

    opll_patch_regs i_patch_regs (
        .clk(clk), .rst(rst), .patch_we(patch_we), .patch_byte(patch_byte),
        .wdata(wdata), .rd_inst(rd_inst), .patch(patch)
    );

    opll_slot_seq i_slot_seq (
        .clk(clk), .rst(rst), .out_ready(out_ready),
        .fnum(fnum), .block(block), .key(key), .sus(sus), .inst(inst), .vol(vol),
        .patch(patch), .rd_chan(rd_chan), .rd_inst(rd_inst),
        .out_valid(out_valid), .out_slot(out_slot), .out_carrier(out_carrier),
        .out_fnum(out_fnum), .out_block(out_block), .out_key(out_key),
        .out_sus(out_sus), .out_am(out_am), .out_vib(out_vib),
        .out_egtyp(out_egtyp), .out_ksr(out_ksr), .out_mul(out_mul),
        .out_ksl(out_ksl), .out_tl(out_tl), .out_wave(out_wave), .out_fb(out_fb),
        .out_ar(out_ar), .out_dr(out_dr), .out_sl(out_sl), .out_rr(out_rr)
    );

endmodule

// ==== opll_checker.sv ====
// testbench checker that watches the slot stream and compares records with the stim expectations
`timescale 1ns/1ps

module opll_checker (
    input  logic       clk,
    input  logic       rst,
    // window control from the testbench top
    input  logic       check_go,
    output logic       done,
    input  logic       out_valid,
    input  logic       out_ready,
    input  logic [4:0] out_slot,
    input  logic [8:0] out_fnum,
    input  logic [5:0] out_tl,
    input  logic [3:0] out_mul,
    input  logic [3:0] out_ar,
    input  logic [3:0] out_dr,
    input  logic [3:0] out_sl,
    input  logic [3:0] out_rr,
    input  logic [2:0] out_block,
    input  logic [2:0] out_fb,
    input  logic [1:0] out_ksl,
    input  logic       out_carrier,
    input  logic       out_key,
    input  logic       out_sus,
    input  logic       out_am,
    input  logic       out_vib,
    input  logic       out_egtyp,
    input  logic       out_ksr,
    input  logic       out_wave
);

    localparam int NUM_FIELD = 18;
    localparam int NUM_SLOT  = 18;

    // field names as the stim file spells them
    string names [NUM_FIELD] = '{"carrier", "fnum", "block", "key", "sus", "am", "vib",
        "egtyp", "ksr", "mul", "ksl", "tl", "wave", "fb", "ar", "dr", "sl", "rr"};

    logic [8:0]  exp_val [NUM_SLOT][NUM_FIELD];
    logic        exp_on  [NUM_SLOT][NUM_FIELD];
    int          err_cnt = 0;
    // slot 0 transfers seen since check_go rose
    logic [1:0]  zero_cnt;
    // slot due on the next transfer, counted here
    logic [4:0]  next_slot;
    logic        stall_q;
    logic [55:0] rec;
    logic [55:0] rec_q;

    // whole record for the stall check
    assign rec = {out_slot, out_carrier, out_fnum, out_block, out_key, out_sus, out_am,
        out_vib, out_egtyp, out_ksr, out_mul, out_ksl, out_tl, out_wave, out_fb,
        out_ar, out_dr, out_sl, out_rr};

    function automatic logic [8:0] field_value(input int idx);
        case (idx)
            0:  return out_carrier;
            1:  return out_fnum;
            2:  return out_block;
            3:  return out_key;
            4:  return out_sus;
            5:  return out_am;
            6:  return out_vib;
            7:  return out_egtyp;
            8:  return out_ksr;
            9:  return out_mul;
            10: return out_ksl;
            11: return out_tl;
            12: return out_wave;
            13: return out_fb;
            14: return out_ar;
            15: return out_dr;
            16: return out_sl;
            default: return out_rr;
        endcase
    endfunction

    task automatic clear_expect();
        for (int s = 0; s < NUM_SLOT; s++) begin
            for (int f = 0; f < NUM_FIELD; f++) begin
                exp_on[s][f] = 1'b0;
            end
        end
    endtask

    // good is low for an unknown field or slot
    task automatic set_expect(input int slot, input string name, input logic [8:0] value,
                              output bit good);
        int idx;
        idx = -1;
        for (int f = 0; f < NUM_FIELD; f++) begin
            if (names[f] == name) begin
                idx = f;
            end
        end
        good = (idx >= 0) && (slot >= 0) && (slot < NUM_SLOT);
        if (good) begin
            exp_val[slot][idx] = value;
            exp_on[slot][idx]  = 1'b1;
        end
    endtask

    always @(posedge clk) begin : watch
        int   errs;
        logic in_window;
        errs = 0;
        if (rst) begin
            if (out_valid) begin
                $display("out_valid high during reset at %0t", $time);
                errs++;
            end
            next_slot <= '0;
            stall_q   <= 1'b0;
            zero_cnt  <= '0;
            done      <= 1'b0;
        end else begin
            // a stalled record must stay put
            if (stall_q && !out_valid) begin
                $display("out_valid dropped without a transfer at %0t", $time);
                errs++;
            end else if (stall_q && rec != rec_q) begin
                $display("CHECK FAILED t=%0t slot %0d record changed while stalled",
                         $time, out_slot);
                errs++;
            end
            stall_q <= out_valid && !out_ready;
            rec_q   <= rec;
            if (out_valid && out_ready) begin
                if (out_slot != next_slot) begin
                    $display("CHECK FAILED t=%0t slot order expected %0d got %0d",
                             $time, next_slot, out_slot);
                    errs++;
                end
                next_slot <= (next_slot == NUM_SLOT - 1) ? 5'd0 : next_slot + 5'd1;
                if (check_go) begin
                    // compare from the second slot 0 up to the third
                    in_window = (out_slot == 0) ? (zero_cnt == 2'd1) : (zero_cnt == 2'd2);
                    if (out_slot == 0 && zero_cnt != 2'd3) begin
                        zero_cnt <= zero_cnt + 2'd1;
                    end
                    if (out_slot == 0 && zero_cnt == 2'd2) begin
                        done <= 1'b1;
                    end
                    for (int f = 0; f < NUM_FIELD; f++) begin
                        if (in_window && exp_on[out_slot][f] &&
                            field_value(f) !== exp_val[out_slot][f]) begin
                            $display("CHECK FAILED t=%0t slot %0d field %s expected %0h got %0h",
                                     $time, out_slot, names[f], exp_val[out_slot][f],
                                     field_value(f));
                            errs++;
                        end
                    end
                end
            end
            if (!check_go) begin
                zero_cnt <= '0;
                done     <= 1'b0;
            end
        end
        if (errs != 0) begin
            err_cnt <= err_cnt + errs;
        end
    end

endmodule

// ==== tb_opll_core.sv ====
// testbench top, runs the opll register front end through the script in opll_stim.txt
`timescale 1ns/1ps

module tb_opll_core;

    localparam int WAIT_LIMIT = 4000;
    localparam int PAT_LEN    = 1024;

    logic        clk;
    logic        rst;
    logic        write;
    logic        addr;
    logic [7:0]  din;
    logic        out_ready;
    logic        out_valid;
    logic [4:0]  out_slot;
    logic [8:0]  out_fnum;
    logic [5:0]  out_tl;
    logic [3:0]  out_mul, out_ar, out_dr, out_sl, out_rr;
    logic [2:0]  out_block, out_fb;
    logic [1:0]  out_ksl;
    logic        out_carrier, out_key, out_sus, out_am, out_vib;
    logic        out_egtyp, out_ksr, out_wave;
    logic        check_go;
    logic        check_done;
    logic        random_ready;
    logic        ready_pat [PAT_LEN];
    int          pat_idx;
    int          seed;
    int          fd;
    int          passes;
    int          fails;
    int          stim_bad;
    int          start_errs;
    bit          have_test;
    string       line;
    string       cur_name;

    opll_core i_opll_core (
        .clk(clk), .rst(rst), .write(write), .addr(addr), .din(din),
        .out_ready(out_ready), .out_valid(out_valid), .out_slot(out_slot),
        .out_carrier(out_carrier), .out_fnum(out_fnum), .out_block(out_block),
        .out_key(out_key), .out_sus(out_sus), .out_am(out_am), .out_vib(out_vib),
        .out_egtyp(out_egtyp), .out_ksr(out_ksr), .out_mul(out_mul), .out_ksl(out_ksl),
        .out_tl(out_tl), .out_wave(out_wave), .out_fb(out_fb), .out_ar(out_ar),
        .out_dr(out_dr), .out_sl(out_sl), .out_rr(out_rr)
    );

    opll_checker i_checker (
        .clk(clk), .rst(rst), .check_go(check_go), .done(check_done),
        .out_valid(out_valid), .out_ready(out_ready), .out_slot(out_slot),
        .out_fnum(out_fnum), .out_tl(out_tl), .out_mul(out_mul), .out_ar(out_ar),
        .out_dr(out_dr), .out_sl(out_sl), .out_rr(out_rr), .out_block(out_block),
        .out_fb(out_fb), .out_ksl(out_ksl), .out_carrier(out_carrier), .out_key(out_key),
        .out_sus(out_sus), .out_am(out_am), .out_vib(out_vib), .out_egtyp(out_egtyp),
        .out_ksr(out_ksr), .out_wave(out_wave)
    );

    always #5 clk = ~clk;

    // downstream ready, always high or from the pre-drawn pattern
    always @(posedge clk) begin
        pat_idx   <= (pat_idx + 1) % PAT_LEN;
        out_ready <= random_ready ? ready_pat[pat_idx] : 1'b1;
    end

    // address write then data write, one cycle each
    task automatic write_pair(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        write <= 1'b1;
        addr  <= 1'b0;
        din   <= a;
        @(posedge clk);
        addr  <= 1'b1;
        din   <= d;
        @(posedge clk);
        write <= 1'b0;
    endtask

    // open the check window and wait for the checker to close it
    task automatic run_test();
        int cycles;
        bit ok;
        @(posedge clk);
        check_go <= 1'b1;
        cycles = 0;
        while (!check_done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!check_done) begin
            $display("test %s stalled, slot 0 did not come round within %0d cycles",
                     cur_name, WAIT_LIMIT);
        end
        ok = check_done && (i_checker.err_cnt == start_errs);
        $display("test %s: %s", cur_name, ok ? "pass" : "fail");
        if (ok) begin
            passes++;
        end else begin
            fails++;
        end
        check_go <= 1'b0;
        cycles = 0;
        while (check_done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (check_done) begin
            $display("checker kept done high after test %s", cur_name);
            stim_bad++;
        end
    endtask

    task automatic handle_line(input string text);
        string      kw;
        string      arg;
        string      f [4];
        logic [8:0] v [4];
        logic [7:0] a;
        logic [7:0] d;
        int         slot;
        int         n;
        bit         good;
        n = $sscanf(text, "%s", kw);
        if (n < 1 || kw == "#") begin
            return;
        end
        if (kw == "T") begin
            if (have_test) begin
                run_test();
            end
            void'($sscanf(text, "%s %s", kw, arg));
            cur_name   = arg;
            have_test  = 1'b1;
            start_errs = i_checker.err_cnt;
            i_checker.clear_expect();
        end else if (kw == "W") begin
            void'($sscanf(text, "%s %h %h", kw, a, d));
            write_pair(a, d);
        end else if (kw == "READY") begin
            void'($sscanf(text, "%s %s", kw, arg));
            random_ready <= (arg == "random");
        end else if (kw == "E") begin
            n = $sscanf(text, "%s %d %s %h %s %h %s %h %s %h", kw, slot,
                        f[0], v[0], f[1], v[1], f[2], v[2], f[3], v[3]);
            for (int i = 0; i < (n - 2) / 2; i++) begin
                i_checker.set_expect(slot, f[i], v[i], good);
                if (!good) begin
                    $display("stim file names an unknown field %s or slot %0d", f[i], slot);
                    stim_bad++;
                end
            end
        end else begin
            $display("stim file line not understood: %s", text);
            stim_bad++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        write        = 1'b0;
        addr         = 1'b0;
        din          = '0;
        out_ready    = 1'b0;
        check_go     = 1'b0;
        random_ready = 1'b0;
        pat_idx      = 0;
        passes       = 0;
        fails        = 0;
        stim_bad     = 0;
        have_test    = 1'b0;
        seed         = 40155;
        void'($urandom(seed));
        // roughly three ready cycles in four
        for (int i = 0; i < PAT_LEN; i++) begin
            ready_pat[i] = ($urandom % 4) != 0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("opll_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open opll_stim.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    handle_line(line);
                end
            end
            $fclose(fd);
            if (have_test) begin
                run_test();
            end
            $display("tests passed %0d, failed %0d, checker errors %0d, stim errors %0d",
                     passes, fails, i_checker.err_cnt, stim_bad);
            if (fails == 0 && stim_bad == 0 && i_checker.err_cnt == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

// ==== sim.f ====
opll_types_pkg.sv
opll_map_pkg.sv
opll_mmr.sv
opll_chan_regs.sv
opll_patch_regs.sv
opll_slot_seq.sv
opll_core.sv
opll_checker.sv
tb_opll_core.sv

// ==== opll_stim.txt ====
# T name | W register data (hex) | READY full or random
# E slot (decimal) then up to four field and value pairs (hex)
T reset_state
E 0 carrier 0 fnum 0 block 0 key 0
E 0 sus 0 am 0 vib 0 egtyp 0
E 0 ksr 0 mul 0 ksl 0 tl 0
E 0 wave 0 fb 0 ar 0 dr 0
E 0 sl 0 rr 0
E 1 carrier 1 tl 0 mul 0 ar 0
T user_patch
W 00 a3
W 01 61
W 02 9c
W 03 d5
W 04 f4
W 05 87
W 06 26
W 07 5a
E 0 am 1 egtyp 1 mul 3 ksl 2
E 0 tl 1c wave 0 fb 5 ar f
E 0 dr 4 sl 2 rr 6 vib 0
E 1 am 0 vib 1 mul 1 ksl 3
E 1 tl 0 wave 1 fb 0 ar 8
E 1 dr 7 sl 5 rr a carrier 1
E 16 mul 3 tl 1c fb 5 rr 6
E 17 mul 1 ksl 3 wave 1 rr a
T rom_patch
W 33 5b
E 6 egtyp 1 ksr 1 mul 2 tl 1e
E 6 fb 6 ar e dr 1 rr 1
E 7 mul 1 tl 2c fb 0 ar 7
E 7 dr 6 sl 2 rr 8 ksl 0
E 0 mul 3 tl 1c
T fnum_split
W 12 a7
W 22 3d
E 4 fnum 1a7 block 6 key 1 sus 1
E 5 fnum 1a7 block 6 key 1 sus 1
E 6 fnum 0 block 0 key 0 sus 0
E 3 fnum 0 key 0
T random_ready
READY random
E 4 fnum 1a7 key 1 block 6
E 7 tl 2c mul 1 rr 8
E 0 mul 3 fb 5
T unmapped
READY full
W 08 ff
W 0f ff
W 19 ff
W 1f ff
W 39 ff
E 4 fnum 1a7 block 6 key 1 sus 1
E 7 tl 2c mul 1 ar 7 rr 8
E 0 mul 3 tl 1c fb 5 ar f
E 17 ksl 3 rr a fnum 0 key 0
